// File: Bender.yml
package:
  name: opn_timer

sources:
  - files:
      - verilog/opn_pkg.sv
      - verilog/opn_timer_if.sv
      - verilog/opn_bus_regs.sv
      - verilog/opn_timer.sv
      - verilog/opn_status.sv
      - verilog/opn_timer_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_opn_timer.sv

// File: list.f
+incdir+test
verilog/opn_pkg.sv
verilog/opn_timer_if.sv
verilog/opn_bus_regs.sv
verilog/opn_timer.sv
verilog/opn_status.sv
verilog/opn_timer_top.sv
test/tb_opn_timer.sv

// File: test/tb_opn_tasks.svh
// Timer testbench tasks

// Control register bit masks
localparam data_t load_a_bit = data_t'(1 << CTL_LOAD_A);
localparam data_t load_b_bit = data_t'(1 << CTL_LOAD_B);
localparam data_t en_a_bit   = data_t'(1 << CTL_EN_A);
localparam data_t en_b_bit   = data_t'(1 << CTL_EN_B);
localparam data_t clr_a_bit  = data_t'(1 << CTL_CLR_A);
localparam data_t clr_b_bit  = data_t'(1 << CTL_CLR_B);
localparam data_t busy_mask  = data_t'(1 << STATUS_BUSY_BIT);

task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_status(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
        stop_with_failure($sformatf("Mismatch at %0t: %s expected %02h, got %02h",
                                    $time, name, expected, actual));
    end
endtask

task automatic check_irq(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        stop_with_failure($sformatf("Mismatch at %0t: %s expected %b, got %b",
                                    $time, name, expected, actual));
    end
endtask

// Measured cycle counts against a nominal period
task automatic check_period(input string name, input int expected, input int actual,
                            input int tol);
    if (actual < expected - tol || actual > expected + tol) begin
        stop_with_failure($sformatf("Mismatch at %0t: %s expected %0d +/- %0d, got %0d",
                                    $time, name, expected, tol, actual));
    end
endtask

task automatic next_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

// Address phase, then data phase
task automatic write_reg(input reg_addr_t reg_num, input data_t value);
    @(posedge clk);
    #1;
    cs_n = 1'b0;
    wr_n = 1'b0;
    addr = 2'b00;
    din  = reg_num;
    @(posedge clk);
    #1;
    addr = 2'b01;
    din  = value;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    wr_n = 1'b1;
    addr = 2'b00;
    din  = '0;
endtask

task automatic read_status(output data_t value);
    value = dout;   // Combinational read, any address
endtask

task automatic write_timer_a(input timer_a_t value);
    write_reg(REG_TA_HI, value[9:2]);
    write_reg(REG_TA_LO, {6'b0, value[1:0]});
endtask

// Loads off and both flags cleared
task automatic stop_timers();
    write_reg(REG_TIMER_CTL, clr_a_bit | clr_b_bit);
    next_cycles(2);
endtask

task automatic wait_flag(input int bit_pos, input int limit, input string what,
                         output int cycles);
    cycles = 0;
    while (dout[bit_pos] !== 1'b1) begin
        if (cycles >= limit) begin
            stop_with_failure($sformatf("%s never set within %0d cycles", what, limit));
        end
        @(posedge clk);
        #1;
        cycles++;
    end
endtask

task automatic test_reset_state();
    data_t st;
    read_status(st);
    check_status("dout after reset", 8'h00, st);
    check_irq("irq_n after reset", 1'b1, irq_n);
endtask

task automatic test_timer_a();
    timer_a_t a_val;
    int       period;
    int       cycles;
    a_val  = timer_a_t'($random(seed));
    period = (1 << TIMER_A_W) - a_val;
    stop_timers();
    write_timer_a(a_val);
    write_reg(REG_TIMER_CTL, load_a_bit | en_a_bit);
    wait_flag(0, period + 10, "timer A flag", cycles);
    check_period("timer A period", period, cycles, 3);
    check_irq("irq_n as flag A sets", 1'b1, irq_n);   // Pin lags by a cycle
    next_cycles(1);
    check_irq("irq_n after flag A", 1'b0, irq_n);
endtask

task automatic test_timer_b();
    timer_b_t b_val;
    int       period;
    int       cycles;
    b_val  = timer_b_t'($random(seed));
    period = TIMER_B_PRESCALE * ((1 << TIMER_B_W) - b_val);
    stop_timers();
    write_reg(REG_TB, b_val);
    write_reg(REG_TIMER_CTL, load_b_bit | en_b_bit);
    wait_flag(1, period + 40, "timer B flag", cycles);
    check_period("timer B period", period, cycles, 20);
    check_irq("irq_n as flag B sets", 1'b1, irq_n);
    next_cycles(1);
    check_irq("irq_n after flag B", 1'b0, irq_n);
endtask

task automatic test_enable_and_clear();
    data_t st;
    int    cycles;
    stop_timers();
    write_timer_a(10'h3f0);   // 16 tick period
    write_reg(REG_TIMER_CTL, load_a_bit);
    // Several overflows go by with the enable low
    repeat (3 * 16 + 4) begin
        next_cycles(1);
        read_status(st);
        check_status("flag A with enable low", 8'h00, st & 8'h01);
    end
    check_irq("irq_n with enable low", 1'b1, irq_n);

    write_reg(REG_TB, 8'hff);
    write_reg(REG_TIMER_CTL, load_a_bit | load_b_bit | en_a_bit | en_b_bit);
    wait_flag(0, 40, "timer A flag", cycles);
    wait_flag(1, 40, "timer B flag", cycles);
    next_cycles(1);
    check_irq("irq_n with both flags", 1'b0, irq_n);

    write_reg(REG_TIMER_CTL, load_a_bit | load_b_bit | clr_a_bit);
    next_cycles(1);
    read_status(st);
    check_status("flags after clear A", 8'h02, st & 8'h03);
    next_cycles(1);
    check_irq("irq_n with flag B left", 1'b0, irq_n);

    write_reg(REG_TIMER_CTL, load_a_bit | load_b_bit | clr_b_bit);
    next_cycles(2);
    read_status(st);
    check_status("flags after clear B", 8'h00, st & 8'h03);
    check_irq("irq_n after both clears", 1'b1, irq_n);
endtask

task automatic test_busy();
    data_t st;
    int    ticks;
    int    cycles;
    stop_timers();
    write_reg(REG_TB, 8'h00);
    read_status(st);
    check_status("busy after data write", busy_mask, st & busy_mask);
    ticks  = 0;
    cycles = 0;
    // cen runs at half rate here
    while (dout[STATUS_BUSY_BIT] !== 1'b0) begin
        if (cycles >= 4 * BUSY_TICKS) begin
            stop_with_failure($sformatf("busy bit never cleared within %0d cycles", cycles));
        end
        @(posedge clk);
        if (cen) begin
            ticks++;
        end
        #1;
        cen = ~cen;
        cycles++;
    end
    cen = 1'b1;
    check_period("busy length in ticks", BUSY_TICKS, ticks, 2);
endtask

task automatic test_both_timers();
    timer_a_t a_val;
    timer_b_t b_val;
    int       period_a;
    int       period_b;
    int       cycles;
    int       cycles_a;
    int       cycles_b;
    int       limit;
    a_val    = timer_a_t'($random(seed));
    b_val    = timer_b_t'($random(seed));
    period_a = (1 << TIMER_A_W) - a_val;
    period_b = TIMER_B_PRESCALE * ((1 << TIMER_B_W) - b_val);
    limit    = ((period_a > period_b) ? period_a : period_b) + 40;
    stop_timers();
    write_timer_a(a_val);
    write_reg(REG_TB, b_val);
    write_reg(REG_TIMER_CTL, load_a_bit | load_b_bit | en_a_bit | en_b_bit);
    cycles   = 0;
    cycles_a = -1;
    cycles_b = -1;
    while (cycles_a < 0 || cycles_b < 0) begin
        if (cycles >= limit) begin
            stop_with_failure($sformatf("timer %s flag never set within %0d cycles",
                                        (cycles_a < 0) ? "A" : "B", limit));
        end
        @(posedge clk);
        #1;
        cycles++;
        if (cycles_a < 0 && dout[0] === 1'b1) begin
            cycles_a = cycles;
        end
        if (cycles_b < 0 && dout[1] === 1'b1) begin
            cycles_b = cycles;
        end
    end
    check_period("timer A period with B running", period_a, cycles_a, 3);
    check_period("timer B period with A running", period_b, cycles_b, 20);
endtask

// File: test/tb_opn_timer.sv
// Timer subsystem testbench
`timescale 1ns/1ps

module tb_opn_timer;
    import opn_pkg::*;

    logic       clk;
    logic       rst;
    logic       cen;
    data_t      din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    data_t      dout;
    logic       irq_n;

    int seed = 7871;   // Timer values come from this seed

    opn_timer_top u_dut (
        .clk    ( clk   ),
        .rst    ( rst   ),
        .cen    ( cen   ),
        .din    ( din   ),
        .addr   ( addr  ),
        .cs_n   ( cs_n  ),
        .wr_n   ( wr_n  ),
        .dout   ( dout  ),
        .irq_n  ( irq_n )
    );

    always #5 clk = ~clk;   // 100 MHz

    `include "tb_opn_tasks.svh"

    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        cen  = 1'b1;
        din  = '0;
        addr = '0;
        cs_n = 1'b1;
        wr_n = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_timer_a();
        test_timer_b();
        test_enable_and_clear();
        test_busy();
        test_both_timers();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog/opn_bus_regs.sv
// Register port and timer control
`timescale 1ns/1ps

module opn_bus_regs (
    input  logic           clk,
    input  logic           rst,
    input  opn_pkg::data_t din,
    input  logic           addr0,
    input  logic           cs_n,
    input  logic           wr_n,
    output logic           data_wr,
    opn_timer_if.ctrl      tmr_a,
    opn_timer_if.ctrl      tmr_b
);
    import opn_pkg::*;

    logic                   bus_wr;
    logic                   addr_wr;
    logic                   ctl_wr;
    reg_addr_t              sel_addr;   // Latched register number
    logic [TIMER_A_W-3:0]   ta_hi;
    logic [1:0]             ta_lo;
    timer_a_t               ta_val;
    timer_b_t               tb_val;
    logic                   load_a;
    logic                   load_b;
    logic                   en_a;
    logic                   en_b;
    logic                   clr_a;
    logic                   clr_b;

    assign bus_wr  = !cs_n && !wr_n;
    assign addr_wr = bus_wr && !addr0;
    assign data_wr = bus_wr && addr0;     // Also starts the busy window
    assign ctl_wr  = data_wr && (sel_addr == REG_TIMER_CTL);

    // Address phase
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_addr <= '0;
        end else if (addr_wr) begin
            sel_addr <= din;
        end
    end

    // Data phase goes to whichever register was latched last
    always_ff @(posedge clk) begin
        if (rst) begin
            ta_hi  <= '0;
            ta_lo  <= '0;
            tb_val <= '0;
            load_a <= 1'b0;
            load_b <= 1'b0;
            en_a   <= 1'b0;
            en_b   <= 1'b0;
        end else if (data_wr) begin
            case (sel_addr)
                REG_TA_HI: ta_hi  <= din;
                REG_TA_LO: ta_lo  <= din[1:0];
                REG_TB:    tb_val <= din;
                REG_TIMER_CTL: begin
                    load_a <= din[CTL_LOAD_A];
                    load_b <= din[CTL_LOAD_B];
                    en_a   <= din[CTL_EN_A];
                    en_b   <= din[CTL_EN_B];
                end
                default: ;  // Other registers belong to the FM core
            endcase
        end
    end

    // Clear bits are not stored, they only fire a pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
        end else begin
            clr_a <= ctl_wr && din[CTL_CLR_A];
            clr_b <= ctl_wr && din[CTL_CLR_B];
        end
    end

    assign ta_val = {ta_hi, ta_lo};

    assign tmr_a.value    = ta_val;
    assign tmr_a.load     = load_a;
    assign tmr_a.irq_en   = en_a;
    assign tmr_a.clr_flag = clr_a;

    assign tmr_b.value    = tb_val;
    assign tmr_b.load     = load_b;
    assign tmr_b.irq_en   = en_b;
    assign tmr_b.clr_flag = clr_b;

    // A held clear would eat an overflow that lands right after it
    a_clr_a_single: assert property (
        @(posedge clk) disable iff (rst) clr_a |=> !clr_a
    ) else $error("timer A clr_flag lasted two cycles");

    a_clr_b_single: assert property (
        @(posedge clk) disable iff (rst) clr_b |=> !clr_b
    ) else $error("timer B clr_flag lasted two cycles");

endmodule

// File: verilog/opn_pkg.sv
// Timer subsystem definitions

package opn_pkg;

    // Widths of the two timers
    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;

    // Timer B counts once every 16 ticks
    localparam int TIMER_B_PRESCALE = 16;

    typedef logic [7:0]           data_t;      // CPU bus byte
    typedef logic [7:0]           reg_addr_t;  // Register number
    typedef logic [TIMER_A_W-1:0] timer_a_t;
    typedef logic [TIMER_B_W-1:0] timer_b_t;

    // Timer register map
    localparam reg_addr_t REG_TA_HI     = 8'h24;  // Timer A bits 9..2
    localparam reg_addr_t REG_TA_LO     = 8'h25;  // Timer A bits 1..0
    localparam reg_addr_t REG_TB        = 8'h26;
    localparam reg_addr_t REG_TIMER_CTL = 8'h27;

    // Bit positions inside REG_TIMER_CTL
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;   // Flag A may set
    localparam int CTL_EN_B   = 3;   // Flag B may set
    localparam int CTL_CLR_A  = 4;
    localparam int CTL_CLR_B  = 5;

    // Busy window after each data write in cen ticks
    localparam int BUSY_TICKS = 32;

    // Busy bit position in the status byte
    localparam int STATUS_BUSY_BIT = 7;

endpackage

// File: verilog/opn_status.sv
// Busy, interrupt and status byte
`timescale 1ns/1ps

module opn_status (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic           data_wr,
    input  logic           flag_a,
    input  logic           flag_b,
    output opn_pkg::data_t dout,
    output logic           irq_n
);
    import opn_pkg::*;

    localparam int BW = $clog2(BUSY_TICKS + 1);

    logic [BW-1:0] busy_cnt;   // Ticks left in the busy window
    logic          busy;

    // A new write always restarts the window
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BW'(BUSY_TICKS);
        end else if (cen && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= !(flag_a || flag_b);   // Active low pin
        end
    end

    // Read path ignores the address
    always_comb begin
        dout                  = '0;
        dout[STATUS_BUSY_BIT] = busy;
        dout[1]               = flag_b;
        dout[0]               = flag_a;
    end

    // After the last write busy must drop once BUSY_TICKS ticks went by
    a_busy_len: assert property (
        @(posedge clk) disable iff (rst)
        data_wr ##1 (!data_wr throughout cen[->BUSY_TICKS]) |=> !busy
    ) else $error("busy stayed high past BUSY_TICKS ticks");

endmodule

// File: verilog/opn_timer.sv
// Reloadable interval timer
`timescale 1ns/1ps

module opn_timer #(
    parameter int W        = 10,
    parameter int PRESCALE = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    opn_timer_if.timer  ctl,
    output logic        flag
);

    // A prescale of one still needs a one bit counter
    localparam int            PW       = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam logic [PW-1:0] PRE_LAST = PW'(PRESCALE - 1);

    logic [PW-1:0] pre;
    logic [W-1:0]  cnt;
    logic          load_q;
    logic          load_rise;
    logic          tick;
    logic          overflow;

    assign load_rise = ctl.load && !load_q;
    assign tick      = cen && (pre == PRE_LAST);
    assign overflow  = ctl.load && !load_rise && tick && (cnt == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_q <= 1'b0;
        end else begin
            load_q <= ctl.load;
        end
    end

    // Tick divider
    always_ff @(posedge clk) begin
        if (rst) begin
            pre <= '0;
        end else if (load_rise) begin
            pre <= '0;
        end else if (cen && ctl.load) begin
            pre <= (pre == PRE_LAST) ? '0 : pre + 1'b1;
        end
    end

    // Up counter with a period of 2^W - value ticks
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (load_rise) begin
            cnt <= ctl.value;
        end else if (ctl.load && tick) begin
            if (cnt == '1) begin
                cnt <= ctl.value;   // Wrap back to the reload value
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Clear wins over a set in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            flag <= 1'b0;
        end else if (ctl.clr_flag) begin
            flag <= 1'b0;
        end else if (overflow && ctl.irq_en) begin
            flag <= 1'b1;
        end
    end

    // The enable is sampled together with the overflow
    a_flag_needs_en: assert property (
        @(posedge clk) disable iff (rst) $rose(flag) |-> $past(ctl.irq_en)
    ) else $error("timer flag rose with irq_en low");

endmodule

// File: verilog/opn_timer_if.sv
// Timer control interface
`timescale 1ns/1ps

interface opn_timer_if #(
    parameter int W = 8
);

    logic [W-1:0] value;     // Reload value
    logic         load;      // Timer runs while high
    logic         irq_en;    // Overflow may raise the flag
    logic         clr_flag;  // Single cycle clear pulse

    // Register block side
    modport ctrl (
        output value,
        output load,
        output irq_en,
        output clr_flag
    );

    // Timer side
    modport timer (
        input  value,
        input  load,
        input  irq_en,
        input  clr_flag
    );

endinterface

// File: verilog/opn_timer_top.sv
// FM chip timer subsystem top
`timescale 1ns/1ps

module opn_timer_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,     // Timer tick enable
    input  opn_pkg::data_t din,
    input  logic [1:0]     addr,    // Bit 1 kept for pin compatibility
    input  logic           cs_n,
    input  logic           wr_n,
    output opn_pkg::data_t dout,
    output logic           irq_n
);
    import opn_pkg::*;

    logic data_wr;
    logic flag_a;
    logic flag_b;

    opn_timer_if #(.W(TIMER_A_W)) tmr_a_if ();
    opn_timer_if #(.W(TIMER_B_W)) tmr_b_if ();

    opn_bus_regs u_regs (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .din        ( din           ),
        .addr0      ( addr[0]       ),
        .cs_n       ( cs_n          ),
        .wr_n       ( wr_n          ),
        .data_wr    ( data_wr       ),
        .tmr_a      ( tmr_a_if.ctrl ),
        .tmr_b      ( tmr_b_if.ctrl )
    );

    // Timer A ticks on every cen
    opn_timer #(
        .W          ( TIMER_A_W     ),
        .PRESCALE   ( 1             )
    ) u_timer_a (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .cen        ( cen           ),
        .ctl        ( tmr_a_if.timer),
        .flag       ( flag_a        )
    );

    opn_timer #(
        .W          ( TIMER_B_W         ),
        .PRESCALE   ( TIMER_B_PRESCALE  )
    ) u_timer_b (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .cen        ( cen           ),
        .ctl        ( tmr_b_if.timer),
        .flag       ( flag_b        )
    );

    opn_status u_status (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .cen        ( cen           ),
        .data_wr    ( data_wr       ),
        .flag_a     ( flag_a        ),
        .flag_b     ( flag_b        ),
        .dout       ( dout          ),
        .irq_n      ( irq_n         )
    );

endmodule
